//--- project.f
src/fetch_pkg.sv
src/fetch_pkt_if.sv
src/fetch_pc_gen.sv
src/pending_pc_fifo.sv
src/fetch_align.sv
src/inst_queue.sv
src/fetch_top.sv
tests/tb_fetch_top.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top -f project.f || exit 1
out=$(./obj_dir/Vtb_fetch_top)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1

//--- src/fetch_align.sv
`timescale 1ns/100ps

module fetch_align
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              redirect,
    input  logic              req_valid,
    input  logic [xlen-1:0]   req_pc,
    input  logic              rsp_valid,
    input  logic [xlen-1:0]   rsp_inst0,
    input  logic [xlen-1:0]   rsp_inst1,
    input  logic [excp_w-1:0] rsp_excp_code,
    input  logic [1:0]        rsp_excp_flag,
    fetch_pkt_if.src          pkt
);

    logic [xlen-1:0]   head_pc;
    logic              hi;        // response belongs to an odd-word pc

    logic              pkt_valid;
    logic [xlen-1:0]   pkt_pc;
    logic [xlen-1:0]   pkt_inst0;
    logic [xlen-1:0]   pkt_inst1;
    logic              pkt_slot1_ok;
    logic [excp_w-1:0] pkt_code;
    logic [1:0]        pkt_flag;

    // cache answers in order, so the head always matches the response
    pending_pc_fifo pend_i (
        .clk     (clk),
        .rstn    (rstn),
        .flush   (redirect),
        .push    (req_valid),
        .push_pc (req_pc),
        .pop     (rsp_valid),
        .head_pc (head_pc)
    );

    assign hi = head_pc[2];

    // a response never meets a full register, the credits see to that
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pkt_valid <= 1'b0;
        end else if (redirect) begin
            pkt_valid <= 1'b0;
        end else if (rsp_valid) begin
            pkt_valid <= 1'b1;
        end else if (pkt.ready) begin
            pkt_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid) begin
            pkt_pc       <= head_pc;
            pkt_inst0    <= hi ? rsp_inst1 : rsp_inst0;
            pkt_inst1    <= hi ? inst_nop : rsp_inst1;
            pkt_slot1_ok <= !hi;
            pkt_code     <= rsp_excp_code;
            pkt_flag     <= hi ? {1'b0, rsp_excp_flag[1]} : rsp_excp_flag;
        end
    end

    assign pkt.valid     = pkt_valid;
    assign pkt.pc        = pkt_pc;
    assign pkt.inst0     = pkt_inst0;
    assign pkt.inst1     = pkt_inst1;
    assign pkt.slot1_ok  = pkt_slot1_ok;
    assign pkt.excp_code = pkt_code;
    assign pkt.excp_flag = pkt_flag;

endmodule

//--- src/fetch_pc_gen.sv
`timescale 1ns/100ps

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            entry_free,
    output logic            req_valid,
    output logic [xlen-1:0] req_pc
);

    logic             active;   // first cycle out of reset
    logic [xlen-1:0]  pc;
    logic [cnt_w-1:0] credit;

    assign req_valid = active && (credit != '0) && !redirect;
    assign req_pc    = pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    // sequential only, next pc drops bit 2 so a misaligned target realigns
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= reset_pc;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (req_valid) begin
            pc <= {pc[xlen-1:3], 3'b000} + xlen'(8);
        end
    end

    // one credit per packet entry, returned when the queue frees it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit <= cnt_w'(queue_depth);
        end else if (redirect) begin
            credit <= cnt_w'(queue_depth); // everything in flight is dropped
        end else begin
            credit <= credit - cnt_w'(req_valid) + cnt_w'(entry_free);
        end
    end

endmodule

//--- src/fetch_pkg.sv
package fetch_pkg;

    // datapath widths
    localparam int xlen   = 32;
    localparam int excp_w = 7;

    // packet entries in inst_queue, also the credit limit for fetch requests
    localparam int queue_depth = 4;
    localparam int cnt_w       = 3;   // holds 0 .. queue_depth

    // in-flight pc queue inside fetch_align
    localparam int pend_depth = 4;    // same as queue_depth, never overflows
    localparam int pend_w     = 2;

    // andi r0, r0, 0
    localparam logic [xlen-1:0] inst_nop = 32'h0340_0000;

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

endpackage

//--- src/fetch_pkt_if.sv
`timescale 1ns/100ps

interface fetch_pkt_if
    import fetch_pkg::*;
();
    logic              valid;
    logic              ready;
    logic [xlen-1:0]   pc;        // address of slot 0
    logic [xlen-1:0]   inst0;
    logic [xlen-1:0]   inst1;
    logic              slot1_ok;  // slot 1 holds a real instruction
    logic [excp_w-1:0] excp_code;
    logic [1:0]        excp_flag; // bit 0 for slot 0

    modport src (
        output valid,
        input  ready,
        output pc,
        output inst0,
        output inst1,
        output slot1_ok,
        output excp_code,
        output excp_flag
    );

    modport dst (
        input  valid,
        output ready,
        input  pc,
        input  inst0,
        input  inst1,
        input  slot1_ok,
        input  excp_code,
        input  excp_flag
    );

endinterface

//--- src/fetch_top.sv
`timescale 1ns/100ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              redirect,
    input  logic [xlen-1:0]   redirect_pc,
    output logic              req_valid,
    output logic [xlen-1:0]   req_pc,
    input  logic              rsp_valid,
    input  logic [xlen-1:0]   rsp_inst0,
    input  logic [xlen-1:0]   rsp_inst1,
    input  logic [excp_w-1:0] rsp_excp_code,
    input  logic [1:0]        rsp_excp_flag,
    input  logic              inst_ready,
    output logic              inst_valid,
    output logic [xlen-1:0]   inst_pc,
    output logic [xlen-1:0]   inst_word,
    output logic              inst_excp,
    output logic [excp_w-1:0] inst_excp_code
);

    logic entry_free;

    fetch_pkt_if pkt_if ();

    fetch_pc_gen pc_gen_i (
        .clk         (clk),
        .rstn        (rstn),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .entry_free  (entry_free),
        .req_valid   (req_valid),
        .req_pc      (req_pc)
    );

    fetch_align align_i (
        .clk           (clk),
        .rstn          (rstn),
        .redirect      (redirect),
        .req_valid     (req_valid),
        .req_pc        (req_pc),
        .rsp_valid     (rsp_valid),
        .rsp_inst0     (rsp_inst0),
        .rsp_inst1     (rsp_inst1),
        .rsp_excp_code (rsp_excp_code),
        .rsp_excp_flag (rsp_excp_flag),
        .pkt           (pkt_if.src)
    );

    inst_queue queue_i (
        .clk            (clk),
        .rstn           (rstn),
        .redirect       (redirect),
        .inst_ready     (inst_ready),
        .pkt            (pkt_if.dst),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_excp      (inst_excp),
        .inst_excp_code (inst_excp_code),
        .entry_free     (entry_free)
    );

endmodule

//--- src/inst_queue.sv
`timescale 1ns/100ps

module inst_queue
    import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic              redirect,
    input  logic              inst_ready,
    fetch_pkt_if.dst          pkt,
    output logic              inst_valid,
    output logic [xlen-1:0]   inst_pc,
    output logic [xlen-1:0]   inst_word,
    output logic              inst_excp,
    output logic [excp_w-1:0] inst_excp_code,
    output logic              entry_free
);

    logic [xlen-1:0]   q_pc    [queue_depth];
    logic [xlen-1:0]   q_inst0 [queue_depth];
    logic [xlen-1:0]   q_inst1 [queue_depth];
    logic              q_ok    [queue_depth];
    logic [excp_w-1:0] q_code  [queue_depth];
    logic [1:0]        q_flag  [queue_depth];

    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    logic [cnt_w-1:0]               count;
    logic                           slot;   // slot within head packet
    logic                           push;
    logic                           fire;
    logic                           last;

    assign pkt.ready = (count != cnt_w'(queue_depth));
    assign push      = pkt.valid && pkt.ready;

    assign inst_valid     = (count != '0);
    assign inst_pc        = slot ? q_pc[rd_ptr] + xlen'(4) : q_pc[rd_ptr];
    assign inst_word      = slot ? q_inst1[rd_ptr] : q_inst0[rd_ptr];
    assign inst_excp      = q_flag[rd_ptr][slot];
    assign inst_excp_code = q_code[rd_ptr];

    assign fire       = inst_valid && inst_ready;
    assign last       = slot || !q_ok[rd_ptr];
    assign entry_free = fire && last;   // one credit back to pc gen

    always_ff @(posedge clk) begin
        if (push) begin
            q_pc[wr_ptr]    <= pkt.pc;
            q_inst0[wr_ptr] <= pkt.inst0;
            q_inst1[wr_ptr] <= pkt.inst1;
            q_ok[wr_ptr]    <= pkt.slot1_ok;
            q_code[wr_ptr]  <= pkt.excp_code;
            q_flag[wr_ptr]  <= pkt.excp_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            slot   <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (entry_free) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(entry_free);
            if (fire) begin
                slot <= !last;
            end
        end
    end

endmodule

//--- src/pending_pc_fifo.sv
`timescale 1ns/100ps

module pending_pc_fifo
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            flush,
    input  logic            push,
    input  logic [xlen-1:0] push_pc,
    input  logic            pop,
    output logic [xlen-1:0] head_pc
);

    logic [xlen-1:0]   pc_mem [pend_depth];
    logic [pend_w-1:0] wr_ptr;
    logic [pend_w-1:0] rd_ptr;

    // credits keep the fill at or below pend_depth, no full check needed
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr] <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1; // wraps at pend_depth
        end
    end

    assign head_pc = pc_mem[rd_ptr]; // oldest outstanding request

endmodule

//--- tests/tb_fetch_top.sv
`timescale 1ns/100ps

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int num_insts  = 600;
    localparam int max_cycles = num_insts * 4;

    typedef struct packed {
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   word;
        logic              excp;
        logic [excp_w-1:0] code;
        logic              last;   // frees the packet entry
    } slot_t;

    logic              clk;
    logic              rstn;
    logic              redirect;
    logic [xlen-1:0]   redirect_pc;
    logic              req_valid;
    logic [xlen-1:0]   req_pc;
    logic              rsp_valid;
    logic [xlen-1:0]   rsp_inst0;
    logic [xlen-1:0]   rsp_inst1;
    logic [excp_w-1:0] rsp_excp_code;
    logic [1:0]        rsp_excp_flag;
    logic              inst_ready;
    logic              inst_valid;
    logic [xlen-1:0]   inst_pc;
    logic [xlen-1:0]   inst_word;
    logic              inst_excp;
    logic [excp_w-1:0] inst_excp_code;

    logic [15:0]     lfsr;
    slot_t           exp_q [$];
    logic [xlen-1:0] cache_pc_q [$];   // accepted requests, oldest first
    int              cache_due_q [$];
    logic [xlen-1:0] next_req;
    logic [xlen-1:0] last_pc;
    logic            have_last;
    int              inflight;
    int              cyc;
    int              retired;
    int              value_errors;
    int              other_errors;

    fetch_top dut_i (.*);

    function automatic int unsigned rand_bits(input int n);
        int unsigned r;
        int          i;
        r = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;
            r = (r << 1) | int'(lfsr[0]);
        end
        return r;
    endfunction

    function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] a);
        return ((a >> 2) * 32'h0001_0003) ^ 32'h6d2b_79f5;
    endfunction

    function automatic logic faults(input logic [xlen-1:0] a);
        return ((a >> 2) % 13) == 0;   // every 13th word
    endfunction

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            $display("CHECK FAILED at %0d ns: %s", $time, what);
            value_errors++;
        end
    endtask

    task automatic push_expected(input logic [xlen-1:0] a);
        logic [xlen-1:0] lo;
        logic [xlen-1:0] hi;
        slot_t           s;
        lo = {a[xlen-1:3], 3'b000};
        hi = lo + 32'd4;
        if (!a[2]) begin
            s.pc   = lo;
            s.word = mem_word(lo);
            s.excp = faults(lo);
            s.code = lo[8:2];
            s.last = 1'b0;
            exp_q.push_back(s);
        end
        s.pc   = hi;
        s.word = mem_word(hi);
        s.excp = faults(hi);
        s.code = hi[8:2];
        s.last = 1'b1;
        exp_q.push_back(s);
    endtask

    task automatic drive_inputs();
        logic [xlen-1:0] lo;
        logic [xlen-1:0] hi;
        redirect = (cyc > 30) && (rand_bits(6) == 0);
        if (redirect) begin
            redirect_pc = reset_pc + (rand_bits(10) << 2);
        end
        inst_ready = (rand_bits(2) != 0);
        rsp_valid  = 1'b0;
        if (!redirect && cache_pc_q.size() != 0 && cache_due_q[0] <= cyc) begin
            lo = {cache_pc_q[0][xlen-1:3], 3'b000};
            hi = lo + 32'd4;
            rsp_valid     = 1'b1;
            rsp_inst0     = mem_word(lo);
            rsp_inst1     = mem_word(hi);
            rsp_excp_flag = {faults(hi), faults(lo)};
            rsp_excp_code = faults(lo) ? lo[8:2] : (faults(hi) ? hi[8:2] : '0);
        end
    endtask

    task automatic observe_cycle();
        slot_t e;
        if (inst_valid && inst_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("error at %0d ns: instruction at pc %h came out with none expected",
                         $time, inst_pc);
                other_errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check(inst_pc === e.pc, $sformatf("pc %h, expected %h", inst_pc, e.pc));
                check(inst_word === e.word,
                      $sformatf("word %h at pc %h, expected %h", inst_word, e.pc, e.word));
                check(inst_excp === e.excp, $sformatf("excp %b at pc %h", inst_excp, e.pc));
                if (e.excp) begin
                    check(inst_excp_code === e.code,
                          $sformatf("excp code %h at pc %h, expected %h",
                                    inst_excp_code, e.pc, e.code));
                end
                if (have_last) begin
                    check(inst_pc === last_pc + 32'd4,
                          $sformatf("pc %h did not step by 4 from %h", inst_pc, last_pc));
                end else begin
                    check(inst_pc === last_pc,
                          $sformatf("first pc %h is not the fetch target %h",
                                    inst_pc, last_pc));
                end
                if (e.last) begin
                    inflight--;
                end
                last_pc   = inst_pc;
                have_last = 1'b1;
            end
            retired++;
        end
        if (rsp_valid) begin
            push_expected(cache_pc_q.pop_front());
            void'(cache_due_q.pop_front());
        end
        if (req_valid) begin
            check(req_pc === next_req, $sformatf("req pc %h, expected %h", req_pc, next_req));
            cache_pc_q.push_back(next_req);
            cache_due_q.push_back(cyc + 1 + int'(rand_bits(2)));   // 0 to 3 cycles late
            next_req = {next_req[xlen-1:3], 3'b000} + 32'd8;
            inflight++;
        end
        if (redirect) begin
            cache_pc_q.delete();
            cache_due_q.delete();
            exp_q.delete();
            inflight  = 0;
            next_req  = redirect_pc;
            last_pc   = redirect_pc;
            have_last = 1'b0;
        end
        check(inflight <= queue_depth, $sformatf("%0d packets in flight", inflight));
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        lfsr          = 16'd67;
        rstn          = 1'b0;
        redirect      = 1'b0;
        redirect_pc   = '0;
        rsp_valid     = 1'b0;
        rsp_inst0     = '0;
        rsp_inst1     = '0;
        rsp_excp_code = '0;
        rsp_excp_flag = '0;
        inst_ready    = 1'b0;
        next_req      = reset_pc;
        last_pc       = reset_pc;
        have_last     = 1'b0;
        inflight      = 0;
        cyc           = 0;
        retired       = 0;
        value_errors  = 0;
        other_errors  = 0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check(!req_valid && !inst_valid, "outputs active in reset");
        end
        rstn = 1'b1;
        while (retired < num_insts && cyc < max_cycles) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);   // inputs settled, handshakes of the next edge
            observe_cycle();
            cyc++;
        end
        assert (retired >= num_insts) else begin
            $display("timeout: only %0d of %0d instructions came out in %0d cycles",
                     retired, num_insts, cyc);
            other_errors++;
        end
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
